// ==== rtl/drain_arbiter.sv ====
`timescale 1ns/10ps
`include "scratchpad_settings.svh"

module drain_arbiter #(
    parameter int WIDTH = 8
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic [`SP_NUM_BANKS-1:0]              q_empty,
    input  logic [`SP_NUM_BANKS-1:0][WIDTH-1:0]   q_data,
    output logic [`SP_NUM_BANKS-1:0]              q_ren,
    input  logic                                  out_ren,
    output logic                                  out_empty,
    output logic [`SP_BANK_W-1:0]                 out_bank,
    output logic [WIDTH-1:0]                      out_data
);

    import scratchpad_pkg::*;

    localparam int BANK_W = `SP_BANK_W;

    arb_state_e        state;
    logic [BANK_W-1:0] last;
    logic [BANK_W-1:0] grant;
    logic [BANK_W-1:0] pick;
    logic [BANK_W-1:0] sel;
    logic              pop;

    // search starts at the bank after the one served last and wraps around.
    always_comb begin
        int  idx;
        logic found;
        pick  = last;
        found = 1'b0;
        for (int i = 1; i <= `SP_NUM_BANKS; i++) begin
            idx = (int'(last) + i) % `SP_NUM_BANKS;
            if (!found && !q_empty[idx]) begin
                pick  = BANK_W'(idx);
                found = 1'b1;
            end
        end
    end

    // a presented item keeps its bank until the consumer takes it.
    assign sel       = (state == ARB_GRANT) ? grant : pick;
    assign out_empty = q_empty[sel];
    assign out_bank  = sel;
    assign out_data  = q_data[sel];
    assign pop       = out_ren && !out_empty;

    always_comb begin
        q_ren = '0;
        if (pop) begin
            q_ren[sel] = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ARB_IDLE;
            grant <= '0;
            last  <= BANK_W'(`SP_NUM_BANKS - 1);
        end else if (pop) begin
            state <= ARB_IDLE;
            last  <= sel;
        end else if (!out_empty) begin
            state <= ARB_GRANT;
            grant <= sel;
        end else begin
            state <= ARB_IDLE;
        end
    end

endmodule

// ==== rtl/request_router.sv ====
`timescale 1ns/10ps
`include "scratchpad_settings.svh"

module request_router (
    input  logic                       wr_en,
    input  logic [`SP_BANK_W-1:0]      wr_bank,
    output logic [`SP_NUM_BANKS-1:0]   bank_wr_en,
    input  logic [`SP_NUM_BANKS-1:0]   bank_wr_full,
    output logic                       wr_full,
    input  logic                       rd_en,
    input  logic [`SP_BANK_W-1:0]      rd_bank,
    output logic [`SP_NUM_BANKS-1:0]   bank_rd_en,
    input  logic [`SP_NUM_BANKS-1:0]   bank_rd_full,
    output logic                       rd_full
);

    // one-hot enable for the addressed bank, all zero when the request is not taken.
    function automatic logic [`SP_NUM_BANKS-1:0] bank_select(
        input logic                  en,
        input logic [`SP_BANK_W-1:0] bank
    );
        logic [`SP_NUM_BANKS-1:0] sel;
        sel = '0;
        if (en) begin
            sel[bank] = 1'b1;
        end
        return sel;
    endfunction

    logic wr_take;
    logic rd_take;

    // the producer only sees the full flag of the bank it addresses.
    assign wr_full = bank_wr_full[wr_bank];
    assign rd_full = bank_rd_full[rd_bank];

    // gating with the flag keeps a full bank from ever receiving an enable.
    assign wr_take = wr_en && !wr_full;
    assign rd_take = rd_en && !rd_full;

    assign bank_wr_en = bank_select(wr_take, wr_bank);
    assign bank_rd_en = bank_select(rd_take, rd_bank);

endmodule

// ==== rtl/scratchpad.sv ====
`timescale 1ns/10ps
`include "scratchpad_settings.svh"

module scratchpad (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       wr_en,
    input  logic [`SP_BANK_W-1:0]      wr_bank,
    input  logic [`SP_MAT_W-1:0]       wr_mat,
    input  logic [`SP_ROW_W-1:0]       wr_row,
    input  logic [`SP_ROW_BITS-1:0]    wr_data,
    input  logic                       wr_gemm,
    output logic                       wr_full,
    input  logic                       rd_en,
    input  logic [`SP_BANK_W-1:0]      rd_bank,
    input  logic [`SP_MAT_W-1:0]       rd_mat,
    input  logic [`SP_ROW_W-1:0]       rd_row,
    input  logic [`SP_ADDR_BITS-1:0]   rd_addr,
    input  scratchpad_pkg::mat_type_e  rd_type,
    output logic                       rd_full,
    output logic                       dram_empty,
    input  logic                       dram_ren,
    output logic [`SP_BANK_W-1:0]      dram_bank,
    output logic [`SP_ADDR_BITS-1:0]   dram_addr,
    output logic [`SP_MAT_W-1:0]       dram_mat,
    output logic [`SP_ROW_W-1:0]       dram_row,
    output logic [`SP_ROW_BITS-1:0]    dram_data,
    output logic                       gemm_empty,
    input  logic                       gemm_ren,
    output logic [`SP_BANK_W-1:0]      gemm_bank,
    output scratchpad_pkg::mat_type_e  gemm_type,
    output logic [`SP_MAT_W-1:0]       gemm_mat,
    output logic [`SP_ROW_W-1:0]       gemm_row,
    output logic [`SP_ROW_BITS-1:0]    gemm_data,
    output logic [`SP_NUM_BANKS-1:0]   load_complete,
    output logic [`SP_NUM_BANKS-1:0]   gemm_complete
);

    import scratchpad_pkg::*;

    localparam int NB     = `SP_NUM_BANKS;
    localparam int DRAM_W = $bits(dram_word_t);
    localparam int GEMM_W = $bits(gemm_word_t);

    logic [NB-1:0]             bank_wr_en;
    logic [NB-1:0]             bank_wr_full;
    logic [NB-1:0]             bank_rd_en;
    logic [NB-1:0]             bank_rd_full;
    logic [NB-1:0]             dram_q_empty;
    logic [NB-1:0]             dram_q_ren;
    logic [NB-1:0][DRAM_W-1:0] dram_q;
    logic [NB-1:0]             gemm_q_empty;
    logic [NB-1:0]             gemm_q_ren;
    logic [NB-1:0][GEMM_W-1:0] gemm_q;
    dram_word_t                dram_out;
    gemm_word_t                gemm_out;

    request_router router_inst (
        .wr_en(wr_en), .wr_bank(wr_bank), .bank_wr_en(bank_wr_en),
        .bank_wr_full(bank_wr_full), .wr_full(wr_full),
        .rd_en(rd_en), .rd_bank(rd_bank), .bank_rd_en(bank_rd_en),
        .bank_rd_full(bank_rd_full), .rd_full(rd_full)
    );

    // request fields go to every bank, only the enables are steered.
    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic [`SP_ADDR_BITS-1:0] b_dram_addr;
        logic [`SP_MAT_W-1:0]     b_dram_mat;
        logic [`SP_ROW_W-1:0]     b_dram_row;
        logic [`SP_ROW_BITS-1:0]  b_dram_data;
        mat_type_e                b_gemm_type;
        logic [`SP_MAT_W-1:0]     b_gemm_mat;
        logic [`SP_ROW_W-1:0]     b_gemm_row;
        logic [`SP_ROW_BITS-1:0]  b_gemm_data;

        scratchpad_bank bank_inst (
            .CLK(CLK), .nRST(nRST),
            .wr_en(bank_wr_en[b]), .wr_gemm(wr_gemm), .wr_mat(wr_mat),
            .wr_row(wr_row), .wr_data(wr_data), .wr_full(bank_wr_full[b]),
            .rd_en(bank_rd_en[b]), .rd_type(rd_type), .rd_mat(rd_mat),
            .rd_row(rd_row), .rd_addr(rd_addr), .rd_full(bank_rd_full[b]),
            .dram_ren(dram_q_ren[b]), .dram_empty(dram_q_empty[b]),
            .dram_addr(b_dram_addr), .dram_mat(b_dram_mat),
            .dram_row(b_dram_row), .dram_data(b_dram_data),
            .gemm_ren(gemm_q_ren[b]), .gemm_empty(gemm_q_empty[b]),
            .gemm_type(b_gemm_type), .gemm_mat(b_gemm_mat),
            .gemm_row(b_gemm_row), .gemm_data(b_gemm_data),
            .load_complete(load_complete[b]), .gemm_complete(gemm_complete[b])
        );

        // field order follows the output word structs.
        assign dram_q[b] = {b_dram_addr, b_dram_mat, b_dram_row, b_dram_data};
        assign gemm_q[b] = {b_gemm_type, b_gemm_mat, b_gemm_row, b_gemm_data};
    end

    drain_arbiter #(.WIDTH(DRAM_W)) dram_arbiter (
        .CLK(CLK), .nRST(nRST),
        .q_empty(dram_q_empty), .q_data(dram_q), .q_ren(dram_q_ren),
        .out_ren(dram_ren), .out_empty(dram_empty), .out_bank(dram_bank),
        .out_data(dram_out)
    );

    drain_arbiter #(.WIDTH(GEMM_W)) gemm_arbiter (
        .CLK(CLK), .nRST(nRST),
        .q_empty(gemm_q_empty), .q_data(gemm_q), .q_ren(gemm_q_ren),
        .out_ren(gemm_ren), .out_empty(gemm_empty), .out_bank(gemm_bank),
        .out_data(gemm_out)
    );

    assign dram_addr = dram_out.addr;
    assign dram_mat  = dram_out.mat;
    assign dram_row  = dram_out.row;
    assign dram_data = dram_out.data;

    assign gemm_type = gemm_out.mat_type;
    assign gemm_mat  = gemm_out.mat;
    assign gemm_row  = gemm_out.row;
    assign gemm_data = gemm_out.data;

endmodule

// ==== rtl/scratchpad_bank.sv ====
`timescale 1ns/10ps
`include "scratchpad_settings.svh"

module scratchpad_bank (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       wr_en,
    input  logic                       wr_gemm,
    input  logic [`SP_MAT_W-1:0]       wr_mat,
    input  logic [`SP_ROW_W-1:0]       wr_row,
    input  logic [`SP_ROW_BITS-1:0]    wr_data,
    output logic                       wr_full,
    input  logic                       rd_en,
    input  scratchpad_pkg::mat_type_e  rd_type,
    input  logic [`SP_MAT_W-1:0]       rd_mat,
    input  logic [`SP_ROW_W-1:0]       rd_row,
    input  logic [`SP_ADDR_BITS-1:0]   rd_addr,
    output logic                       rd_full,
    input  logic                       dram_ren,
    output logic                       dram_empty,
    output logic [`SP_ADDR_BITS-1:0]   dram_addr,
    output logic [`SP_MAT_W-1:0]       dram_mat,
    output logic [`SP_ROW_W-1:0]       dram_row,
    output logic [`SP_ROW_BITS-1:0]    dram_data,
    input  logic                       gemm_ren,
    output logic                       gemm_empty,
    output scratchpad_pkg::mat_type_e  gemm_type,
    output logic [`SP_MAT_W-1:0]       gemm_mat,
    output logic [`SP_ROW_W-1:0]       gemm_row,
    output logic [`SP_ROW_BITS-1:0]    gemm_data,
    output logic                       load_complete,
    output logic                       gemm_complete
);

    import scratchpad_pkg::*;

    localparam int ROW_W = `SP_ROW_W;
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`SP_ROWS_PER_MAT - 1);

    logic [`SP_MATS_PER_BANK-1:0][`SP_ROWS_PER_MAT-1:0][`SP_ROW_BITS-1:0] rows;

    wr_word_t   wr_in;
    wr_word_t   wr_head;
    rd_word_t   rd_in;
    rd_word_t   rd_head;
    dram_word_t dram_in;
    dram_word_t dram_head;
    gemm_word_t gemm_in;
    gemm_word_t gemm_head;

    logic                    wr_empty;
    logic                    wr_pop;
    logic                    rd_empty;
    logic                    rd_pop;
    logic                    is_store;
    logic                    dram_full;
    logic                    gemm_full;
    logic                    dram_push;
    logic                    gemm_push;
    logic [`SP_ROW_BITS-1:0] rd_row_data;

    assign wr_in = '{gemm: wr_gemm, mat: wr_mat, row: wr_row, data: wr_data};
    assign rd_in = '{mat_type: rd_type, mat: rd_mat, row: rd_row, addr: rd_addr};

    sync_fifo #(.WIDTH($bits(wr_word_t)), .DEPTH(`SP_IN_DEPTH)) wr_fifo (
        .CLK(CLK), .nRST(nRST),
        .wen(wr_en), .ren(wr_pop), .wdata(wr_in), .rdata(wr_head),
        .full(wr_full), .empty(wr_empty)
    );

    sync_fifo #(.WIDTH($bits(rd_word_t)), .DEPTH(`SP_IN_DEPTH)) rd_fifo (
        .CLK(CLK), .nRST(nRST),
        .wen(rd_en), .ren(rd_pop), .wdata(rd_in), .rdata(rd_head),
        .full(rd_full), .empty(rd_empty)
    );

    // the write queue drains one entry per cycle, so its head is stored at the next edge.
    assign wr_pop = !wr_empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else if (wr_pop) begin
            rows[wr_head.mat][wr_head.row] <= wr_head.data;
        end
    end

    // the last row of a matrix closes it, the flag tells a load from a GEMM result.
    assign load_complete = wr_pop && (wr_head.row == LAST_ROW) && !wr_head.gemm;
    assign gemm_complete = wr_pop && (wr_head.row == LAST_ROW) && wr_head.gemm;

    // a blocked head stalls every read behind it, which keeps the bank's reads in order.
    assign is_store    = (rd_head.mat_type == MAT_STORE);
    assign dram_push   = !rd_empty && is_store && !dram_full;
    assign gemm_push   = !rd_empty && !is_store && !gemm_full;
    assign rd_pop      = dram_push || gemm_push;
    assign rd_row_data = rows[rd_head.mat][rd_head.row];

    assign dram_in = '{addr: rd_head.addr, mat: rd_head.mat, row: rd_head.row,
                       data: rd_row_data};
    assign gemm_in = '{mat_type: rd_head.mat_type, mat: rd_head.mat, row: rd_head.row,
                       data: rd_row_data};

    sync_fifo #(.WIDTH($bits(dram_word_t)), .DEPTH(`SP_OUT_DEPTH)) dram_fifo (
        .CLK(CLK), .nRST(nRST),
        .wen(dram_push), .ren(dram_ren), .wdata(dram_in), .rdata(dram_head),
        .full(dram_full), .empty(dram_empty)
    );

    sync_fifo #(.WIDTH($bits(gemm_word_t)), .DEPTH(`SP_OUT_DEPTH)) gemm_fifo (
        .CLK(CLK), .nRST(nRST),
        .wen(gemm_push), .ren(gemm_ren), .wdata(gemm_in), .rdata(gemm_head),
        .full(gemm_full), .empty(gemm_empty)
    );

    assign dram_addr = dram_head.addr;
    assign dram_mat  = dram_head.mat;
    assign dram_row  = dram_head.row;
    assign dram_data = dram_head.data;

    assign gemm_type = gemm_head.mat_type;
    assign gemm_mat  = gemm_head.mat;
    assign gemm_row  = gemm_head.row;
    assign gemm_data = gemm_head.data;

endmodule

// ==== rtl/scratchpad_pkg.sv ====
`include "scratchpad_settings.svh"

package scratchpad_pkg;

    // a store read goes to DRAM, every other type is consumed by the GEMM array.
    typedef enum logic [1:0] {
        MAT_STORE   = 2'd0,
        MAT_WEIGHT  = 2'd1,
        MAT_INPUT   = 2'd2,
        MAT_PARTIAL = 2'd3
    } mat_type_e;

    // the arbiter either searches for a bank or holds the bank it presents.
    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_GRANT = 1'b1
    } arb_state_e;

    // entry of a bank's write queue.
    typedef struct packed {
        logic                      gemm;
        logic [`SP_MAT_W-1:0]      mat;
        logic [`SP_ROW_W-1:0]      row;
        logic [`SP_ROW_BITS-1:0]   data;
    } wr_word_t;

    // entry of a bank's read queue.
    typedef struct packed {
        mat_type_e                 mat_type;
        logic [`SP_MAT_W-1:0]      mat;
        logic [`SP_ROW_W-1:0]      row;
        logic [`SP_ADDR_BITS-1:0]  addr;
    } rd_word_t;

    typedef struct packed {
        logic [`SP_ADDR_BITS-1:0]  addr;
        logic [`SP_MAT_W-1:0]      mat;
        logic [`SP_ROW_W-1:0]      row;
        logic [`SP_ROW_BITS-1:0]   data;
    } dram_word_t;

    typedef struct packed {
        mat_type_e                 mat_type;
        logic [`SP_MAT_W-1:0]      mat;
        logic [`SP_ROW_W-1:0]      row;
        logic [`SP_ROW_BITS-1:0]   data;
    } gemm_word_t;

endpackage

// ==== rtl/scratchpad_settings.svh ====
`ifndef SCRATCHPAD_SETTINGS_SVH
`define SCRATCHPAD_SETTINGS_SVH

// scratchpad geometry.
`define SP_NUM_BANKS     2
`define SP_MATS_PER_BANK 4
`define SP_ROWS_PER_MAT  4

// datapath widths.
`define SP_ROW_BITS      64
`define SP_ADDR_BITS     32

// queue depths, input side and output side of a bank.
`define SP_IN_DEPTH      2
`define SP_OUT_DEPTH     8

// select widths derived from the geometry above.
`define SP_BANK_W        ($clog2(`SP_NUM_BANKS))
`define SP_MAT_W         ($clog2(`SP_MATS_PER_BANK))
`define SP_ROW_W         ($clog2(`SP_ROWS_PER_MAT))

`endif

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             wen,
    input  logic             ren,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // requests against a full or an empty buffer are dropped here.
    assign do_write = wen && !full;
    assign do_read  = ren && !empty;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);
    assign rdata = mem[rd_ptr];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f src.f --top-module scratchpad_tb \
    -o scratchpad_sim > "$LOG" 2>&1 &&
    ./obj_dir/scratchpad_sim >> "$LOG" 2>&1 ||
    echo "build or simulation ended with an error" >> "$LOG"

grep -qx "RESULT: PASS" "$LOG" && echo "simulation passed" ||
    { echo "simulation failed, see $LOG"; exit 1; }

// ==== src.f ====
+incdir+rtl
rtl/scratchpad_pkg.sv
rtl/sync_fifo.sv
rtl/scratchpad_bank.sv
rtl/request_router.sv
rtl/drain_arbiter.sv
rtl/scratchpad.sv
tests/scratchpad_assertions.sv
tests/scratchpad_tb.sv

// ==== tests/scratchpad_assertions.sv ====
`timescale 1ns/10ps
`include "scratchpad_settings.svh"

module scratchpad_assertions (
    input logic                     CLK,
    input logic                     nRST,
    input logic                     dram_ren,
    input logic                     dram_empty,
    input logic                     gemm_ren,
    input logic                     gemm_empty,
    input logic                     wr_full,
    input logic [`SP_NUM_BANKS-1:0] load_complete,
    input logic [`SP_NUM_BANKS-1:0] gemm_complete
);

    // a consumer only pops a stream that presents an item.
    dram_pop_ok: assert property (@(posedge CLK) disable iff (!nRST) dram_ren |-> !dram_empty)
        else $error("DRAM stream popped while empty");

    gemm_pop_ok: assert property (@(posedge CLK) disable iff (!nRST) gemm_ren |-> !gemm_empty)
        else $error("GEMM stream popped while empty");

    // every completion is a single-cycle pulse per bank.
    for (genvar b = 0; b < `SP_NUM_BANKS; b++) begin : g_pulse
        load_pulse_width: assert property (@(posedge CLK) disable iff (!nRST)
            load_complete[b] |=> !load_complete[b])
            else $error("load_complete[%0d] lasted more than one cycle", b);

        gemm_pulse_width: assert property (@(posedge CLK) disable iff (!nRST)
            gemm_complete[b] |=> !gemm_complete[b])
            else $error("gemm_complete[%0d] lasted more than one cycle", b);
    end

    // the write queues start empty, so nothing can be full right after reset.
    reset_not_full: assert property (@(posedge CLK) $rose(nRST) |=> !wr_full)
        else $error("wr_full high in the first cycle after reset");

endmodule

bind scratchpad scratchpad_assertions scratchpad_assertions_inst (
    .CLK(CLK), .nRST(nRST),
    .dram_ren(dram_ren), .dram_empty(dram_empty),
    .gemm_ren(gemm_ren), .gemm_empty(gemm_empty),
    .wr_full(wr_full),
    .load_complete(load_complete), .gemm_complete(gemm_complete)
);

// ==== tests/scratchpad_tb.sv ====
`timescale 1ns/10ps
`include "scratchpad_settings.svh"

module scratchpad_tb;

    import scratchpad_pkg::*;

    localparam int NB      = `SP_NUM_BANKS;
    localparam int BANK_W  = `SP_BANK_W;
    localparam int MAT_W   = `SP_MAT_W;
    localparam int ROW_W   = `SP_ROW_W;
    localparam int DATA_W  = `SP_ROW_BITS;
    localparam int ADDR_W  = `SP_ADDR_BITS;
    localparam int MATS    = `SP_MATS_PER_BANK;
    localparam int ROWS    = `SP_ROWS_PER_MAT;
    localparam int MAX_OPS = 48;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_DRAIN} op_e;

    // data holds the write data or the read data that the shadow model predicts.
    typedef struct packed {
        op_e               op;
        logic [BANK_W-1:0] bank;
        logic [MAT_W-1:0]  mat;
        logic [ROW_W-1:0]  row;
        logic              gemm;
        mat_type_e         mat_type;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              hold;
        logic              expect_full;
    } op_t;

    logic CLK = 1'b0;
    logic nRST;
    logic wr_en, wr_gemm, wr_full, rd_en, rd_full;
    logic [BANK_W-1:0] wr_bank, rd_bank, dram_bank, gemm_bank;
    logic [MAT_W-1:0] wr_mat, rd_mat, dram_mat, gemm_mat;
    logic [ROW_W-1:0] wr_row, rd_row, dram_row, gemm_row;
    logic [DATA_W-1:0] wr_data, dram_data, gemm_data;
    logic [ADDR_W-1:0] rd_addr, dram_addr;
    mat_type_e rd_type, gemm_type;
    logic dram_empty, dram_ren, gemm_empty, gemm_ren;
    logic [NB-1:0] load_complete, gemm_complete;

    op_t ops [MAX_OPS];
    int n_ops;
    int error_count;
    integer seed;
    bit table_ready;
    bit dram_hold;
    logic [DATA_W-1:0] shadow [NB][MATS][ROWS];
    int exp_dram [NB][$];
    int exp_gemm [NB][$];

    scratchpad scratchpad_inst (
        .CLK(CLK), .nRST(nRST),
        .wr_en(wr_en), .wr_bank(wr_bank), .wr_mat(wr_mat), .wr_row(wr_row),
        .wr_data(wr_data), .wr_gemm(wr_gemm), .wr_full(wr_full),
        .rd_en(rd_en), .rd_bank(rd_bank), .rd_mat(rd_mat), .rd_row(rd_row),
        .rd_addr(rd_addr), .rd_type(rd_type), .rd_full(rd_full),
        .dram_empty(dram_empty), .dram_ren(dram_ren), .dram_bank(dram_bank),
        .dram_addr(dram_addr), .dram_mat(dram_mat), .dram_row(dram_row), .dram_data(dram_data),
        .gemm_empty(gemm_empty), .gemm_ren(gemm_ren), .gemm_bank(gemm_bank),
        .gemm_type(gemm_type), .gemm_mat(gemm_mat), .gemm_row(gemm_row), .gemm_data(gemm_data),
        .load_complete(load_complete), .gemm_complete(gemm_complete)
    );

    always #10 CLK = ~CLK;

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED t=%0t: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    task automatic check_pulse(input logic [NB-1:0] exp_load, input logic [NB-1:0] exp_gemm);
        if (load_complete !== exp_load || gemm_complete !== exp_gemm) begin
            report_mismatch($sformatf("pulses load %b gemm %b, expected load %b gemm %b",
                load_complete, gemm_complete, exp_load, exp_gemm));
        end
    endtask

    task automatic check_dram(input logic [BANK_W-1:0] bank, input logic [ADDR_W-1:0] addr,
                              input logic [MAT_W-1:0] mat, input logic [ROW_W-1:0] row,
                              input logic [DATA_W-1:0] data);
        if (dram_bank !== bank || dram_addr !== addr || dram_mat !== mat ||
            dram_row !== row || dram_data !== data) begin
            report_mismatch($sformatf(
                "DRAM item b%0d a%h m%0d r%0d d%h, expected b%0d a%h m%0d r%0d d%h",
                dram_bank, dram_addr, dram_mat, dram_row, dram_data,
                bank, addr, mat, row, data));
        end
    endtask

    task automatic check_gemm(input logic [BANK_W-1:0] bank, input mat_type_e mtype,
                              input logic [MAT_W-1:0] mat, input logic [ROW_W-1:0] row,
                              input logic [DATA_W-1:0] data);
        if (gemm_bank !== bank || gemm_type !== mtype || gemm_mat !== mat ||
            gemm_row !== row || gemm_data !== data) begin
            report_mismatch($sformatf(
                "GEMM item b%0d %s m%0d r%0d d%h, expected b%0d %s m%0d r%0d d%h",
                gemm_bank, gemm_type.name(), gemm_mat, gemm_row, gemm_data,
                bank, mtype.name(), mat, row, data));
        end
    endtask

    task automatic add_op(input op_e op, input int bank, input int mat, input int row,
                          input logic gemm, input mat_type_e mtype, input logic hold,
                          input logic expect_full);
        op_t e;
        e = '0;
        e.op = op;
        e.bank = BANK_W'(bank);
        e.mat = MAT_W'(mat);
        e.row = ROW_W'(row);
        e.gemm = gemm;
        e.mat_type = mtype;
        e.addr = 32'h1000_0000 + ADDR_W'(n_ops * 16);
        e.hold = hold;
        e.expect_full = expect_full;
        if (op == OP_WRITE) begin
            e.data = {$random(seed), $random(seed)};
            shadow[bank][mat][row] = e.data;
        end else begin
            e.data = shadow[bank][mat][row];
        end
        ops[n_ops] = e;
        n_ops++;
    endtask

    task automatic build_table();
        foreach (shadow[b, m, r]) begin
            shadow[b][m][r] = '0;
        end
        // rows that were never written read back as zero.
        add_op(OP_READ, 0, 1, 2, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_READ, 1, 3, 0, 1'b0, MAT_WEIGHT, 1'b0, 1'b0);
        // bank 0 loads mat 0 while bank 1 receives a GEMM result into its own mat 0.
        for (int r = 0; r < ROWS; r++) add_op(OP_WRITE, 0, 0, r, 1'b0, MAT_STORE, 1'b0, 1'b0);
        for (int r = 0; r < ROWS; r++) add_op(OP_WRITE, 1, 0, r, 1'b1, MAT_STORE, 1'b0, 1'b0);
        for (int r = 0; r < ROWS; r++) add_op(OP_READ, 0, 0, r, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_READ, 1, 0, 0, 1'b0, MAT_INPUT, 1'b0, 1'b0);
        add_op(OP_READ, 1, 0, 1, 1'b0, MAT_PARTIAL, 1'b0, 1'b0);
        add_op(OP_READ, 1, 0, 2, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_READ, 1, 0, 3, 1'b0, MAT_WEIGHT, 1'b0, 1'b0);
        add_op(OP_READ, 0, 0, 1, 1'b0, MAT_WEIGHT, 1'b0, 1'b0);
        add_op(OP_WRITE, 0, 3, 3, 1'b1, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_READ, 0, 3, 3, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_DRAIN, 0, 0, 0, 1'b0, MAT_STORE, 1'b0, 1'b0);
        // ten stores against a held DRAM stream fill the output queue and the read queue.
        for (int r = 0; r < ROWS; r++) add_op(OP_WRITE, 1, 2, r, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_DRAIN, 0, 0, 0, 1'b0, MAT_STORE, 1'b1, 1'b0);
        for (int i = 0; i < 10; i++) add_op(OP_READ, 1, 2, i % ROWS, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_DRAIN, 1, 0, 0, 1'b0, MAT_STORE, 1'b0, 1'b1);
        add_op(OP_READ, 0, 3, 3, 1'b0, MAT_PARTIAL, 1'b0, 1'b0);
        add_op(OP_READ, 1, 2, 3, 1'b0, MAT_STORE, 1'b0, 1'b0);
        add_op(OP_DRAIN, 0, 0, 0, 1'b0, MAT_STORE, 1'b0, 1'b0);
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    // full only rises through our own requests, so a low flag at mid-cycle stays low.
    task automatic wait_for_space(input logic is_read);
        @(negedge CLK);
        while (is_read ? rd_full : wr_full) @(negedge CLK);
        next_cycle();
    endtask

    task automatic apply_write(input op_t e);
        logic [NB-1:0] exp_load;
        logic [NB-1:0] exp_gemm;
        exp_load = '0;
        exp_gemm = '0;
        if (e.row == ROW_W'(ROWS - 1)) begin
            if (e.gemm) exp_gemm[e.bank] = 1'b1;
            else exp_load[e.bank] = 1'b1;
        end
        wr_bank = e.bank;
        wr_mat = e.mat;
        wr_row = e.row;
        wr_data = e.data;
        wr_gemm = e.gemm;
        wait_for_space(1'b0);
        wr_en = 1'b1;
        next_cycle();
        wr_en = 1'b0;
        check_pulse(exp_load, exp_gemm);
    endtask

    task automatic apply_read(input int idx);
        op_t e;
        e = ops[idx];
        rd_bank = e.bank;
        rd_mat = e.mat;
        rd_row = e.row;
        rd_addr = e.addr;
        rd_type = e.mat_type;
        wait_for_space(1'b1);
        rd_en = 1'b1;
        next_cycle();
        rd_en = 1'b0;
        // a store is owed to the DRAM stream and every other type to the GEMM stream.
        if (e.mat_type == MAT_STORE) exp_dram[e.bank].push_back(idx);
        else exp_gemm[e.bank].push_back(idx);
    endtask

    function automatic bit drained();
        bit done;
        done = dram_empty && gemm_empty;
        for (int b = 0; b < NB; b++) begin
            if (exp_dram[b].size() != 0 || exp_gemm[b].size() != 0) done = 1'b0;
        end
        return done;
    endfunction

    task automatic apply_drain(input op_t e);
        if (e.hold) begin
            dram_hold = 1'b1;
        end else begin
            if (e.expect_full) begin
                rd_bank = e.bank;
                @(negedge CLK);
                check_flag("rd_full with the DRAM stream held", rd_full, 1'b1);
                next_cycle();
            end
            dram_hold = 1'b0;
            while (!drained()) next_cycle();
        end
    endtask

    task automatic take_dram_item();
        int idx;
        if (exp_dram[dram_bank].size() == 0) begin
            $display("the DRAM stream delivered an item from bank %0d nobody asked for", dram_bank);
            stop_on_failure();
        end else begin
            idx = exp_dram[dram_bank].pop_front();
            check_dram(ops[idx].bank, ops[idx].addr, ops[idx].mat, ops[idx].row, ops[idx].data);
        end
    endtask

    task automatic take_gemm_item();
        int idx;
        if (exp_gemm[gemm_bank].size() == 0) begin
            $display("the GEMM stream delivered an item from bank %0d nobody asked for", gemm_bank);
            stop_on_failure();
        end else begin
            idx = exp_gemm[gemm_bank].pop_front();
            check_gemm(ops[idx].bank, ops[idx].mat_type, ops[idx].mat, ops[idx].row,
                       ops[idx].data);
        end
    endtask

    // the consumers check the head item and pop it at the following edge.
    initial begin
        dram_ren = 1'b0;
        forever begin
            next_cycle();
            dram_ren = 1'b0;
            if (nRST && !dram_empty && !dram_hold) begin
                take_dram_item();
                dram_ren = 1'b1;
            end
        end
    end

    initial begin
        gemm_ren = 1'b0;
        forever begin
            next_cycle();
            gemm_ren = 1'b0;
            if (nRST && !gemm_empty) begin
                take_gemm_item();
                gemm_ren = 1'b1;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (16 + n_ops * 40) @(posedge CLK);
        $display("watchdog expired before the test sequence finished");
        stop_on_failure();
    end

    initial begin
        bit wrote;
        nRST = 1'b0;
        wr_en = 1'b0;
        wr_bank = '0;
        wr_mat = '0;
        wr_row = '0;
        wr_data = '0;
        wr_gemm = 1'b0;
        rd_en = 1'b0;
        rd_bank = '0;
        rd_mat = '0;
        rd_row = '0;
        rd_addr = '0;
        rd_type = MAT_STORE;
        seed = 92957;
        n_ops = 0;
        error_count = 0;
        dram_hold = 1'b0;
        wrote = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge CLK);
        #2;
        nRST = 1'b1;
        check_flag("dram_empty after reset", dram_empty, 1'b1);
        check_flag("gemm_empty after reset", gemm_empty, 1'b1);
        check_pulse('0, '0);
        for (int b = 0; b < NB; b++) begin
            wr_bank = BANK_W'(b);
            rd_bank = BANK_W'(b);
            @(negedge CLK);
            check_flag("wr_full after reset", wr_full, 1'b0);
            check_flag("rd_full after reset", rd_full, 1'b0);
            next_cycle();
        end
        for (int i = 0; i < n_ops; i++) begin
            case (ops[i].op)
                OP_WRITE: begin
                    apply_write(ops[i]);
                    wrote = 1'b1;
                end
                OP_READ: begin
                    // rows written just before a read have to reach the array first.
                    if (wrote) begin
                        while (wr_full) next_cycle();
                        repeat (2) next_cycle();
                        wrote = 1'b0;
                    end
                    apply_read(i);
                end
                default: apply_drain(ops[i]);
            endcase
        end
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
